// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = lane_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/lane.sv ====
/*
 * Vector lane top level
 * Sequencer, operand requester, banked VRF, three operand
 * queues (ALU A, ALU B, store) and the integer ALU
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module lane (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 insn_valid_i,
  input  lane_pkg::alu_op_e    op_i,
  input  lane_pkg::sew_e       sew_i,
  input  logic [`LANE_RW-1:0]  vd_i,
  input  logic [`LANE_RW-1:0]  vs1_i,
  input  logic [`LANE_RW-1:0]  vs2_i,
  input  logic [`LANE_VLW-1:0] vl_i,
  output logic                 insn_ready_o,
  output logic                 insn_done_o,
  input  logic                 ld_req_i,
  input  logic [`LANE_AW-1:0]  ld_addr_i,
  input  logic [`LANE_DW-1:0]  ld_wdata_i,
  output logic                 ld_gnt_o,
  output logic [`LANE_DW-1:0]  st_data_o,
  output logic                 st_valid_o,
  input  logic                 st_ready_i
);

  logic                                          elem_valid;
  logic                                          elem_ready;
  lane_pkg::alu_op_e                             op;
  lane_pkg::sew_e                                sew;
  logic             [`LANE_AW-1:0]               rd_a_addr;
  logic             [`LANE_AW-1:0]               rd_b_addr;
  logic             [`LANE_AW-1:0]               wr_addr;
  logic                                          alu_elem_done;
  logic                                          wr_req;
  logic                                          wr_gnt;
  logic             [`LANE_DW-1:0]               wr_data;
  logic             [`LANE_NR_BANKS-1:0]         bank_req;
  logic             [`LANE_NR_BANKS-1:0]         bank_wen;
  logic             [`LANE_NR_BANKS-1:0][`LANE_AW-1:0] bank_addr;
  logic             [`LANE_NR_BANKS-1:0][`LANE_DW-1:0] bank_wdata;
  lane_pkg::queue_e [`LANE_NR_BANKS-1:0]         bank_tgt;
  logic             [`LANE_NR_QUEUES-1:0][`LANE_DW-1:0] rdata;
  logic             [`LANE_NR_QUEUES-1:0]        rvalid;
  logic             [`LANE_NR_QUEUES-1:0]        pop;
  logic             [`LANE_DW-1:0]               a_data;
  logic             [`LANE_DW-1:0]               b_data;
  logic                                          a_valid;
  logic                                          b_valid;
  logic                                          a_ready;
  logic                                          b_ready;

  assign pop = {st_valid_o && st_ready_i, b_valid && b_ready, a_valid && a_ready};

  lane_sequencer u_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_valid_i   (insn_valid_i),
    .op_i           (op_i),
    .sew_i          (sew_i),
    .vd_i           (vd_i),
    .vs1_i          (vs1_i),
    .vs2_i          (vs2_i),
    .vl_i           (vl_i),
    .insn_ready_o   (insn_ready_o),
    .elem_valid_o   (elem_valid),
    .op_o           (op),
    .rd_a_addr_o    (rd_a_addr),
    .rd_b_addr_o    (rd_b_addr),
    .wr_addr_o      (wr_addr),
    .elem_ready_i   (elem_ready),
    .sew_o          (sew),
    .insn_done_o    (insn_done_o),
    .alu_elem_done_i(alu_elem_done),
    .st_pop_i       (pop[lane_pkg::Q_STORE])
  );

  operand_requester u_requester (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .elem_valid_i(elem_valid),
    .op_i        (op),
    .rd_a_addr_i (rd_a_addr),
    .rd_b_addr_i (rd_b_addr),
    .wr_addr_i   (wr_addr),
    .elem_ready_o(elem_ready),
    .ld_req_i    (ld_req_i),
    .ld_addr_i   (ld_addr_i),
    .ld_wdata_i  (ld_wdata_i),
    .ld_gnt_o    (ld_gnt_o),
    .wr_req_i    (wr_req),
    .wr_data_i   (wr_data),
    .wr_gnt_o    (wr_gnt),
    .pop_i       (pop),
    .bank_req_o  (bank_req),
    .bank_wen_o  (bank_wen),
    .bank_addr_o (bank_addr),
    .bank_wdata_o(bank_wdata),
    .bank_tgt_o  (bank_tgt)
  );

  vector_regfile u_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bank_req_i  (bank_req),
    .bank_wen_i  (bank_wen),
    .bank_addr_i (bank_addr),
    .bank_wdata_i(bank_wdata),
    .bank_tgt_i  (bank_tgt),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid)
  );

  operand_queue u_queue_a (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (rvalid[lane_pkg::Q_ALU_A]),
    .data_i (rdata[lane_pkg::Q_ALU_A]),
    .data_o (a_data),
    .valid_o(a_valid),
    .ready_i(a_ready)
  );

  operand_queue u_queue_b (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (rvalid[lane_pkg::Q_ALU_B]),
    .data_i (rdata[lane_pkg::Q_ALU_B]),
    .data_o (b_data),
    .valid_o(b_valid),
    .ready_i(b_ready)
  );

  operand_queue u_queue_st (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (rvalid[lane_pkg::Q_STORE]),
    .data_i (rdata[lane_pkg::Q_STORE]),
    .data_o (st_data_o),
    .valid_o(st_valid_o),
    .ready_i(st_ready_i)
  );

  vector_alu u_alu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sew_i      (sew),
    .op_i       (op),
    .a_data_i   (a_data),
    .a_valid_i  (a_valid),
    .a_ready_o  (a_ready),
    .b_data_i   (b_data),
    .b_valid_i  (b_valid),
    .b_ready_o  (b_ready),
    .wr_req_o   (wr_req),
    .wr_data_o  (wr_data),
    .wr_gnt_i   (wr_gnt),
    .elem_done_o(alu_elem_done)
  );

endmodule

// ==== hw/lane_params.svh ====
/*
 * Sizes of the vector lane: datapath width, register file shape,
 * vector length limits and operand queue depth
 */
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// Datapath and element word width
`define LANE_DW 32
// Register file shape
`define LANE_NR_VREGS 8
`define LANE_VLMAX 8
`define LANE_NR_BANKS 2
// Address = vreg * VLMAX + element, bank in the low bits
`define LANE_AW 6
// Vector register index and vector length widths
`define LANE_RW 3
`define LANE_VLW 4
// Operand queues: ALU A, ALU B, store
`define LANE_NR_QUEUES 3
`define LANE_QDEPTH 2

`endif

// ==== hw/lane_pkg.sv ====
/*
 * Lane types: ALU opcode, element width, the two views of an
 * element word, and the operand queue tag
 */
`include "lane_params.svh"

package lane_pkg;

  typedef enum logic [2:0] {
    ADD   = 3'd0,
    SUB   = 3'd1,
    AND   = 3'd2,
    XOR   = 3'd3,
    STORE = 3'd4
  } alu_op_e;

  typedef enum logic {
    SEW32 = 1'b0,
    SEW8  = 1'b1
  } sew_e;

  // One VRF word, seen as a single element or as packed bytes
  typedef union packed {
    logic [`LANE_DW-1:0]              w32;
    logic [`LANE_DW/8-1:0][7:0]       b8;
  } elem_u;

  // Index into the operand queue arrays
  typedef enum logic [1:0] {
    Q_ALU_A = 2'd0,
    Q_ALU_B = 2'd1,
    Q_STORE = 2'd2
  } queue_e;

endpackage

// ==== hw/lane_sequencer.sv ====
/*
 * Lane sequencer
 * Takes one vector instruction at a time, issues one element
 * request per handshake and counts completed elements up to vl
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module lane_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  insn_valid_i,
  input  lane_pkg::alu_op_e     op_i,
  input  lane_pkg::sew_e        sew_i,
  input  logic [`LANE_RW-1:0]   vd_i,
  input  logic [`LANE_RW-1:0]   vs1_i,
  input  logic [`LANE_RW-1:0]   vs2_i,
  input  logic [`LANE_VLW-1:0]  vl_i,
  output logic                  insn_ready_o,
  output logic                  elem_valid_o,
  output lane_pkg::alu_op_e     op_o,
  output logic [`LANE_AW-1:0]   rd_a_addr_o,
  output logic [`LANE_AW-1:0]   rd_b_addr_o,
  output logic [`LANE_AW-1:0]   wr_addr_o,
  input  logic                  elem_ready_i,
  output lane_pkg::sew_e        sew_o,
  output logic                  insn_done_o,
  input  logic                  alu_elem_done_i,
  input  logic                  st_pop_i
);

  localparam int unsigned IW = `LANE_AW - `LANE_RW;

  logic                 busy_q;
  lane_pkg::alu_op_e    op_q;
  lane_pkg::sew_e       sew_q;
  logic [`LANE_VLW-1:0] vl_q;
  logic [`LANE_VLW-1:0] iss_cnt_q;
  logic [`LANE_VLW-1:0] done_cnt_q;
  logic [`LANE_RW-1:0]  vd_q;
  logic [`LANE_RW-1:0]  vs1_q;
  logic [`LANE_RW-1:0]  vs2_q;
  logic                 accept;
  logic                 elem_fire;
  logic                 done_inc;

  assign insn_ready_o = !busy_q;
  assign accept       = insn_valid_i && !busy_q;
  assign elem_valid_o = busy_q && (iss_cnt_q < vl_q);
  assign elem_fire    = elem_valid_o && elem_ready_i;

  // A store reads vs1 and completes on store queue pops
  assign done_inc    = busy_q && ((op_q == lane_pkg::STORE) ? st_pop_i : alu_elem_done_i);
  assign insn_done_o = done_inc && (done_cnt_q + `LANE_VLW'(1) == vl_q);

  assign op_o        = op_q;
  assign sew_o       = sew_q;
  assign rd_a_addr_o = {vs1_q, iss_cnt_q[IW-1:0]};
  assign rd_b_addr_o = {vs2_q, iss_cnt_q[IW-1:0]};
  assign wr_addr_o   = {vd_q, iss_cnt_q[IW-1:0]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      op_q       <= lane_pkg::ADD;
      sew_q      <= lane_pkg::SEW32;
      vl_q       <= '0;
      iss_cnt_q  <= '0;
      done_cnt_q <= '0;
    end else if (accept) begin
      busy_q     <= 1'b1;
      op_q       <= op_i;
      sew_q      <= sew_i;
      vl_q       <= vl_i;
      iss_cnt_q  <= '0;
      done_cnt_q <= '0;
    end else begin
      if (elem_fire) begin
        iss_cnt_q <= iss_cnt_q + 1'b1;
      end
      if (done_inc) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
      if (insn_done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Register numbers of the running instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q  <= vd_i;
      vs1_q <= vs1_i;
      vs2_q <= vs2_i;
    end
  end

endmodule

// ==== hw/operand_queue.sv ====
/*
 * Operand queue
 * Small FIFO between the VRF read port and one consumer,
 * space is guaranteed by the requester's credits
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module operand_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic [`LANE_DW-1:0] data_i,
  output logic [`LANE_DW-1:0] data_o,
  output logic                valid_o,
  input  logic                ready_i
);

  localparam int unsigned PW = $clog2(`LANE_QDEPTH);
  localparam int unsigned CW = $clog2(`LANE_QDEPTH + 1);

  logic [`LANE_DW-1:0] mem_q [`LANE_QDEPTH];
  logic [PW-1:0]       wr_ptr_q;
  logic [PW-1:0]       rd_ptr_q;
  logic [CW-1:0]       cnt_q;
  logic                pop;

  assign valid_o = cnt_q != '0;
  assign data_o  = mem_q[rd_ptr_q];
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PW'(`LANE_QDEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(`LANE_QDEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CW'(push_i) - CW'(pop);
    end
  end

endmodule

// ==== hw/operand_requester.sv ====
/*
 * Operand requester
 * Per-bank fixed priority: ALU write, load write, operand reads
 * Same-bank A/B reads are split, A first
 * Credit counters keep each operand queue from overflowing
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module operand_requester (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           elem_valid_i,
  input  lane_pkg::alu_op_e                              op_i,
  input  logic             [`LANE_AW-1:0]                rd_a_addr_i,
  input  logic             [`LANE_AW-1:0]                rd_b_addr_i,
  input  logic             [`LANE_AW-1:0]                wr_addr_i,
  output logic                                           elem_ready_o,
  input  logic                                           ld_req_i,
  input  logic             [`LANE_AW-1:0]                ld_addr_i,
  input  logic             [`LANE_DW-1:0]                ld_wdata_i,
  output logic                                           ld_gnt_o,
  input  logic                                           wr_req_i,
  input  logic             [`LANE_DW-1:0]                wr_data_i,
  output logic                                           wr_gnt_o,
  input  logic             [`LANE_NR_QUEUES-1:0]         pop_i,
  output logic             [`LANE_NR_BANKS-1:0]          bank_req_o,
  output logic             [`LANE_NR_BANKS-1:0]          bank_wen_o,
  output logic             [`LANE_NR_BANKS-1:0][`LANE_AW-1:0] bank_addr_o,
  output logic             [`LANE_NR_BANKS-1:0][`LANE_DW-1:0] bank_wdata_o,
  output lane_pkg::queue_e [`LANE_NR_BANKS-1:0]          bank_tgt_o
);

  localparam int unsigned BW  = $clog2(`LANE_NR_BANKS);
  localparam int unsigned CRW = $clog2(`LANE_QDEPTH + 1);
  // Pending element, queued operands and the ALU result bound the writes in flight
  localparam int unsigned WA_DEPTH = 4;

  logic                              pend_a_q;
  logic                              pend_b_q;
  lane_pkg::alu_op_e                 pend_op_q;
  logic [`LANE_AW-1:0]               pend_a_addr_q;
  logic [`LANE_AW-1:0]               pend_b_addr_q;
  logic [`LANE_AW-1:0]               wa_q [WA_DEPTH];
  logic [$clog2(WA_DEPTH)-1:0]       wa_wr_q;
  logic [$clog2(WA_DEPTH)-1:0]       wa_rd_q;
  logic [`LANE_NR_QUEUES-1:0][CRW-1:0] credit_q;
  logic [`LANE_NR_QUEUES-1:0]        iss;
  logic [BW-1:0]                     wr_bank;
  logic [BW-1:0]                     ld_bank;
  logic [BW-1:0]                     a_bank;
  logic [BW-1:0]                     b_bank;
  lane_pkg::queue_e                  a_tgt;
  logic                              a_free;
  logic                              b_free;
  logic                              a_issue;
  logic                              b_issue;
  logic                              elem_fire;

  //////////////////////
  // Arbitration

  // The ALU is the top priority and is never stalled here
  assign wr_gnt_o = wr_req_i;
  assign wr_bank  = wa_q[wa_rd_q][BW-1:0];
  assign ld_bank  = ld_addr_i[BW-1:0];
  assign ld_gnt_o = ld_req_i && !(wr_req_i && ld_bank == wr_bank);

  assign a_bank = pend_a_addr_q[BW-1:0];
  assign b_bank = pend_b_addr_q[BW-1:0];
  assign a_tgt  = (pend_op_q == lane_pkg::STORE) ? lane_pkg::Q_STORE : lane_pkg::Q_ALU_A;
  assign a_free = !(wr_req_i && wr_bank == a_bank) && !(ld_gnt_o && ld_bank == a_bank);
  assign b_free = !(wr_req_i && wr_bank == b_bank) && !(ld_gnt_o && ld_bank == b_bank);

  assign a_issue = pend_a_q && a_free && (credit_q[a_tgt] != '0);
  // B goes with A only on the other bank, otherwise after it
  assign b_issue = pend_b_q && b_free && (credit_q[lane_pkg::Q_ALU_B] != '0) &&
                   (!pend_a_q || (a_issue && a_bank != b_bank));

  assign elem_ready_o = (!pend_a_q || a_issue) && (!pend_b_q || b_issue);
  assign elem_fire    = elem_valid_i && elem_ready_o;

  always_comb begin
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      bank_req_o[b]   = 1'b0;
      bank_wen_o[b]   = 1'b0;
      bank_addr_o[b]  = '0;
      bank_wdata_o[b] = '0;
      bank_tgt_o[b]   = lane_pkg::Q_ALU_A;
      if (wr_req_i && wr_bank == BW'(b)) begin
        bank_req_o[b]   = 1'b1;
        bank_wen_o[b]   = 1'b1;
        bank_addr_o[b]  = wa_q[wa_rd_q];
        bank_wdata_o[b] = wr_data_i;
      end else if (ld_gnt_o && ld_bank == BW'(b)) begin
        bank_req_o[b]   = 1'b1;
        bank_wen_o[b]   = 1'b1;
        bank_addr_o[b]  = ld_addr_i;
        bank_wdata_o[b] = ld_wdata_i;
      end else if (a_issue && a_bank == BW'(b)) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = pend_a_addr_q;
        bank_tgt_o[b]  = a_tgt;
      end else if (b_issue && b_bank == BW'(b)) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = pend_b_addr_q;
        bank_tgt_o[b]  = lane_pkg::Q_ALU_B;
      end
    end
  end

  //////////////////////
  // Pending element and credits

  always_comb begin
    iss = '0;
    if (a_issue) begin
      iss[a_tgt] = 1'b1;
    end
    if (b_issue) begin
      iss[lane_pkg::Q_ALU_B] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_a_q  <= 1'b0;
      pend_b_q  <= 1'b0;
      pend_op_q <= lane_pkg::ADD;
      wa_wr_q   <= '0;
      wa_rd_q   <= '0;
      for (int q = 0; q < `LANE_NR_QUEUES; q++) begin
        credit_q[q] <= CRW'(`LANE_QDEPTH);
      end
    end else begin
      if (elem_fire) begin
        pend_a_q  <= 1'b1;
        pend_b_q  <= op_i != lane_pkg::STORE;
        pend_op_q <= op_i;
      end else begin
        pend_a_q <= pend_a_q && !a_issue;
        pend_b_q <= pend_b_q && !b_issue;
      end
      if (elem_fire && op_i != lane_pkg::STORE) begin
        wa_wr_q <= wa_wr_q + 1'b1;
      end
      if (wr_gnt_o) begin
        wa_rd_q <= wa_rd_q + 1'b1;
      end
      for (int q = 0; q < `LANE_NR_QUEUES; q++) begin
        credit_q[q] <= credit_q[q] + CRW'(pop_i[q]) - CRW'(iss[q]);
      end
    end
  end

  // Operand addresses and ALU write addresses in element order
  always_ff @(posedge clk_i) begin
    if (elem_fire) begin
      pend_a_addr_q <= rd_a_addr_i;
      pend_b_addr_q <= rd_b_addr_i;
    end
    if (elem_fire && op_i != lane_pkg::STORE) begin
      wa_q[wa_wr_q] <= wr_addr_i;
    end
  end

endmodule

// ==== hw/vector_alu.sv ====
/*
 * Element-wise integer ALU
 * add, sub, and, xor on one 32-bit element or four packed bytes,
 * result held as a VRF write request until granted
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module vector_alu (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lane_pkg::sew_e      sew_i,
  input  lane_pkg::alu_op_e   op_i,
  input  logic [`LANE_DW-1:0] a_data_i,
  input  logic                a_valid_i,
  output logic                a_ready_o,
  input  logic [`LANE_DW-1:0] b_data_i,
  input  logic                b_valid_i,
  output logic                b_ready_o,
  output logic                wr_req_o,
  output logic [`LANE_DW-1:0] wr_data_o,
  input  logic                wr_gnt_i,
  output logic                elem_done_o
);

  lane_pkg::elem_u     a;
  lane_pkg::elem_u     b;
  lane_pkg::elem_u     res_d;
  logic [`LANE_DW-1:0] res_q;
  logic                res_valid_q;
  logic                free;
  logic                take;

  assign a = a_data_i;
  assign b = b_data_i;

  // Both operands leave their queues together
  assign free      = !res_valid_q || wr_gnt_i;
  assign take      = a_valid_i && b_valid_i && free;
  assign a_ready_o = free && b_valid_i;
  assign b_ready_o = free && a_valid_i;

  always_comb begin
    res_d = '0;
    case (op_i)
      lane_pkg::ADD: begin
        if (sew_i == lane_pkg::SEW32) begin
          res_d.w32 = a.w32 + b.w32;
        end else begin
          // Byte lanes, carries stay inside each byte
          for (int i = 0; i < `LANE_DW / 8; i++) begin
            res_d.b8[i] = a.b8[i] + b.b8[i];
          end
        end
      end
      lane_pkg::SUB: begin
        if (sew_i == lane_pkg::SEW32) begin
          res_d.w32 = a.w32 - b.w32;
        end else begin
          for (int i = 0; i < `LANE_DW / 8; i++) begin
            res_d.b8[i] = a.b8[i] - b.b8[i];
          end
        end
      end
      lane_pkg::AND: res_d.w32 = a.w32 & b.w32;
      lane_pkg::XOR: res_d.w32 = a.w32 ^ b.w32;
      default: res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (take) begin
      res_valid_q <= 1'b1;
    end else if (wr_gnt_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      res_q <= res_d.w32;
    end
  end

  assign wr_req_o    = res_valid_q;
  assign wr_data_o   = res_q;
  assign elem_done_o = res_valid_q && wr_gnt_i;

endmodule

// ==== hw/vector_regfile.sv ====
/*
 * Banked vector register file
 * One access per bank per cycle, read data one cycle later,
 * routed to the operand queue named by the request tag
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module vector_regfile (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic             [`LANE_NR_BANKS-1:0]         bank_req_i,
  input  logic             [`LANE_NR_BANKS-1:0]         bank_wen_i,
  input  logic             [`LANE_NR_BANKS-1:0][`LANE_AW-1:0] bank_addr_i,
  input  logic             [`LANE_NR_BANKS-1:0][`LANE_DW-1:0] bank_wdata_i,
  input  lane_pkg::queue_e [`LANE_NR_BANKS-1:0]         bank_tgt_i,
  output logic             [`LANE_NR_QUEUES-1:0][`LANE_DW-1:0] rdata_o,
  output logic             [`LANE_NR_QUEUES-1:0]        rvalid_o
);

  localparam int unsigned BW    = $clog2(`LANE_NR_BANKS);
  localparam int unsigned DEPTH = (1 << `LANE_AW) / `LANE_NR_BANKS;

  logic [`LANE_DW-1:0] rd_data_q  [`LANE_NR_BANKS];
  logic                rd_valid_q [`LANE_NR_BANKS];
  lane_pkg::queue_e    rd_tgt_q   [`LANE_NR_BANKS];

  for (genvar b = 0; b < `LANE_NR_BANKS; b++) begin : gen_bank
    logic [`LANE_DW-1:0]    mem [DEPTH];
    logic [`LANE_AW-BW-1:0] row;

    // Low address bits select the bank, the rest the row
    assign row = bank_addr_i[b][`LANE_AW-1:BW];

    always_ff @(posedge clk_i) begin
      if (bank_req_i[b] && bank_wen_i[b]) begin
        mem[row] <= bank_wdata_i[b];
      end
      if (bank_req_i[b] && !bank_wen_i[b]) begin
        rd_data_q[b] <= mem[row];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_valid_q[b] <= 1'b0;
        rd_tgt_q[b]   <= lane_pkg::Q_ALU_A;
      end else begin
        rd_valid_q[b] <= bank_req_i[b] && !bank_wen_i[b];
        rd_tgt_q[b]   <= bank_tgt_i[b];
      end
    end
  end

  // Banks never target the same queue in one cycle
  always_comb begin
    rdata_o  = '0;
    rvalid_o = '0;
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      if (rd_valid_q[b]) begin
        rvalid_o[rd_tgt_q[b]] = 1'b1;
        rdata_o[rd_tgt_q[b]]  = rd_data_q[b];
      end
    end
  end

endmodule

// ==== tests/lane_sva.sv ====
/*
 * Protocol checks for the vector lane
 * Store stream stability, instruction busy window and
 * completion pulse
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module lane_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                insn_valid_i,
  input logic                insn_ready_o,
  input logic                insn_done_o,
  input logic [`LANE_DW-1:0] st_data_o,
  input logic                st_valid_o,
  input logic                st_ready_i
);

  // Number of failed checks
  int unsigned fail_cnt = 0;

  // Stalled store beat keeps its data
  st_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_valid_o && !st_ready_i |=> st_valid_o && $stable(st_data_o))
    else begin
      $error("store beat dropped or changed while stalled");
      fail_cnt++;
    end

  // Busy from acceptance up to the completion pulse
  insn_accept_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_valid_i && insn_ready_o |=> !insn_ready_o)
    else begin
      $error("lane still ready after taking an instruction");
      fail_cnt++;
    end

  insn_stay_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !insn_ready_o && !insn_done_o |=> !insn_ready_o)
    else begin
      $error("lane became ready without a completion pulse");
      fail_cnt++;
    end

  insn_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_done_o |=> !insn_done_o && insn_ready_o)
    else begin
      $error("completion pulse longer than one cycle");
      fail_cnt++;
    end

endmodule

bind lane lane_sva u_sva (.*);

// ==== tests/lane_tb.sv ====
/*
 * Testbench for the vector lane
 * Loads random registers, runs ALU instructions and stores,
 * checks store beats against a VRF reference model
 */
`timescale 1ns/100ps
`include "lane_params.svh"

module lane_tb;

  localparam int TIMEOUT  = 500;
  localparam int W_LD_GNT = 0;
  localparam int W_READY  = 1;
  localparam int W_DONE   = 2;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 insn_valid_i;
  lane_pkg::alu_op_e    op_i;
  lane_pkg::sew_e       sew_i;
  logic [`LANE_RW-1:0]  vd_i;
  logic [`LANE_RW-1:0]  vs1_i;
  logic [`LANE_RW-1:0]  vs2_i;
  logic [`LANE_VLW-1:0] vl_i;
  logic                 insn_ready_o;
  logic                 insn_done_o;
  logic                 ld_req_i;
  logic [`LANE_AW-1:0]  ld_addr_i;
  logic [`LANE_DW-1:0]  ld_wdata_i;
  logic                 ld_gnt_o;
  logic [`LANE_DW-1:0]  st_data_o;
  logic                 st_valid_o;
  logic                 st_ready_i = 1'b1;

  logic [`LANE_DW-1:0]  ref_vrf [`LANE_NR_VREGS][`LANE_VLMAX];
  logic [`LANE_DW-1:0]  exp_q [$];
  logic [`LANE_DW-1:0]  exp_word;
  logic                 bp_pat [256];
  logic                 bp_en = 1'b0;
  logic [7:0]           cyc = '0;
  int                   err_cnt = 0;
  int                   tmo_cnt = 0;
  int                   acc_cnt = 0;
  int                   done_cnt = 0;
  logic                 report_done = 1'b0;

  lane u_dut (.*);

  always #20 clk_i = ~clk_i;

  //////////////////////
  // Reference model

  function automatic logic [`LANE_DW-1:0] alu_ref(input lane_pkg::alu_op_e op,
      input lane_pkg::sew_e sew, input logic [`LANE_DW-1:0] a, input logic [`LANE_DW-1:0] b);
    logic [`LANE_DW-1:0] r;
    logic [7:0]          x;
    logic [7:0]          y;
    case (op)
      lane_pkg::ADD: r = a + b;
      lane_pkg::SUB: r = a - b;
      lane_pkg::AND: r = a & b;
      lane_pkg::XOR: r = a ^ b;
      default:       r = '0;
    endcase
    // Byte elements wrap on their own
    if (sew == lane_pkg::SEW8 && (op == lane_pkg::ADD || op == lane_pkg::SUB)) begin
      for (int i = 0; i < `LANE_DW / 8; i++) begin
        x = a[8*i +: 8];
        y = b[8*i +: 8];
        r[8*i +: 8] = (op == lane_pkg::ADD) ? x + y : x - y;
      end
    end
    return r;
  endfunction

  //////////////////////
  // Handshake helpers

  function automatic logic probe(input int sel);
    case (sel)
      W_LD_GNT: return ld_gnt_o;
      W_READY:  return insn_ready_o;
      default:  return insn_done_o;
    endcase
  endfunction

  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!probe(sel) && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!probe(sel)) begin
      tmo_cnt++;
      $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
    end
  endtask

  task automatic load_word(input int addr, input logic [`LANE_DW-1:0] data);
    @(posedge clk_i);
    ld_req_i   <= 1'b1;
    ld_addr_i  <= `LANE_AW'(addr);
    ld_wdata_i <= data;
    wait_high(W_LD_GNT, "load grant");
    @(posedge clk_i);
    ld_req_i <= 1'b0;
  endtask

  task automatic load_vreg(input int r);
    logic [`LANE_DW-1:0] w;
    for (int i = 0; i < `LANE_VLMAX; i++) begin
      w = $urandom;
      ref_vrf[r][i] = w;
      load_word(r * `LANE_VLMAX + i, w);
    end
  endtask

  task automatic run_insn(input lane_pkg::alu_op_e op, input lane_pkg::sew_e sew,
                          input int vd, input int vs1, input int vs2, input int vl);
    @(posedge clk_i);
    insn_valid_i <= 1'b1;
    op_i         <= op;
    sew_i        <= sew;
    vd_i         <= `LANE_RW'(vd);
    vs1_i        <= `LANE_RW'(vs1);
    vs2_i        <= `LANE_RW'(vs2);
    vl_i         <= `LANE_VLW'(vl);
    wait_high(W_READY, "instruction ready");
    @(posedge clk_i);
    insn_valid_i <= 1'b0;
    wait_high(W_DONE, "instruction completion");
    @(posedge clk_i);
  endtask

  task automatic alu_insn(input lane_pkg::alu_op_e op, input lane_pkg::sew_e sew,
                          input int vd, input int vs1, input int vs2, input int vl);
    for (int i = 0; i < vl; i++) begin
      ref_vrf[vd][i] = alu_ref(op, sew, ref_vrf[vs1][i], ref_vrf[vs2][i]);
    end
    run_insn(op, sew, vd, vs1, vs2, vl);
  endtask

  task automatic store_vreg(input int r, input int vl);
    for (int i = 0; i < vl; i++) begin
      exp_q.push_back(ref_vrf[r][i]);
    end
    run_insn(lane_pkg::STORE, lane_pkg::SEW32, 0, r, 0, vl);
    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("error %0t: store of v%0d ended with %0d beats missing", $time, r, exp_q.size());
    end
    exp_q.delete();
  endtask

  //////////////////////
  // Monitors

  // Random stalls on the store stream
  always @(posedge clk_i) begin
    cyc        <= cyc + 8'd1;
    st_ready_i <= bp_en ? bp_pat[cyc] : 1'b1;
  end

  always @(negedge clk_i) begin
    if (rst_ni && st_valid_o && st_ready_i) begin
      assert (exp_q.size() != 0) else begin
        err_cnt++;
        $display("error %0t: unexpected store beat %h", $time, st_data_o);
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert (st_data_o === exp_word) else begin
          err_cnt++;
          $display("error %0t: store beat %h, expected %h", $time, st_data_o, exp_word);
        end
      end
    end
    if (rst_ni && insn_valid_i && insn_ready_o) begin
      acc_cnt++;
    end
    if (rst_ni && insn_done_o) begin
      done_cnt++;
    end
  end

  //////////////////////
  // Main sequence

  initial begin
    void'($urandom(77));
    for (int i = 0; i < 256; i++) begin
      bp_pat[i] = 1'($urandom);
    end
    rst_ni       = 1'b0;
    insn_valid_i = 1'b0;
    op_i         = lane_pkg::ADD;
    sew_i        = lane_pkg::SEW32;
    vd_i         = '0;
    vs1_i        = '0;
    vs2_i        = '0;
    vl_i         = '0;
    ld_req_i     = 1'b0;
    ld_addr_i    = '0;
    ld_wdata_i   = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (insn_ready_o === 1'b1 && st_valid_o === 1'b0 &&
            ld_gnt_o === 1'b0 && insn_done_o === 1'b0) else begin
      err_cnt++;
      $display("error %0t: after reset ready=%b st_valid=%b ld_gnt=%b done=%b",
               $time, insn_ready_o, st_valid_o, ld_gnt_o, insn_done_o);
    end

    load_vreg(1);
    load_vreg(2);
    load_vreg(3);
    store_vreg(1, 8);

    alu_insn(lane_pkg::ADD, lane_pkg::SEW32, 4, 1, 2, 8);
    store_vreg(4, 8);
    alu_insn(lane_pkg::SUB, lane_pkg::SEW8, 5, 1, 2, 8);
    store_vreg(5, 8);
    alu_insn(lane_pkg::AND, lane_pkg::SEW32, 6, 2, 3, 8);
    store_vreg(6, 8);
    alu_insn(lane_pkg::XOR, lane_pkg::SEW32, 7, 1, 3, 5);
    store_vreg(7, 5);
    // Both sources from one register
    alu_insn(lane_pkg::XOR, lane_pkg::SEW8, 0, 6, 6, 3);
    store_vreg(0, 3);

    @(posedge clk_i);
    bp_en <= 1'b1;
    store_vreg(4, 8);
    store_vreg(5, 8);
    store_vreg(1, 8);
    @(posedge clk_i);
    bp_en <= 1'b0;

    @(posedge clk_i);
    assert (acc_cnt == done_cnt) else begin
      err_cnt++;
      $display("error %0t: %0d instructions accepted, %0d completed", $time, acc_cnt, done_cnt);
    end

    $display("Errors: %0d check, %0d protocol, %0d timeout",
             err_cnt, u_dut.u_sva.fail_cnt, tmo_cnt);
    report_done = 1'b1;
    if (err_cnt == 0 && u_dut.u_sva.fail_cnt == 0 && tmo_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Run stopped early by a failed protocol check
  final begin
    if (!report_done) begin
      $display("Simulation FAILED");
    end
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/lane_pkg.sv
hw/vector_regfile.sv
hw/operand_queue.sv
hw/lane_sequencer.sv
hw/operand_requester.sv
hw/vector_alu.sv
hw/lane.sv
tests/lane_sva.sv
tests/lane_tb.sv
